// ==== sources.f ====
logic/erx_pkg.sv
logic/erx_cfg_pkg.sv
logic/erx_protocol.sv
logic/erx_remap.sv
logic/erx_cfg.sv
logic/erx_mailbox.sv
logic/erx_distributor.sv
logic/erx_core.sv
bench/erx_core_sva.sv
bench/erx_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= erx_core_tb
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)
	./$(OBJDIR)/$(TOP) | tee /dev/stderr | grep -q "Verification passed"

clean:
	rm -rf $(OBJDIR)

// ==== bench/erx_stimulus.txt ====
# op a b c d e f, all hex; op1 link: write dst data src exp_queue(0 none 1 wr 2 rd 3 rr) exp_dst
# op2 cfg write: addr data; op3 cfg read: addr reply_dst exp_data; op4 flags: full not_empty; op5 rand waits: en
1 1 12345678 00000011 0a000001 1 12345678
1 0 40000010 00000000 0a000002 2 40000010
1 1 800e0004 00000022 0a000003 3 800e0004
1 1 20000000 00000033 0a000004 1 20000000
2 04 00001000 0 0 0 0
2 08 00000a00 0 0 0 0
3 04 0aa00000 00001000 0 0 0
3 08 0aa00004 00000a00 0 0 0
2 00 00003c01 0 0 0 0
3 00 0aa00008 00003c01 0 0 0
1 1 12345678 00000044 0a000005 1 a2345678
1 0 40000010 00000000 0a000006 2 a0000010
1 1 800e0008 00000055 0a000007 3 800e0008
2 00 00000002 0 0 0 0
1 1 12345678 00000066 0a000008 1 12346678
1 0 40000010 00000000 0a000009 2 40001010
1 1 800e000c 00000077 0a00000a 3 800e000c
2 00 00000000 0 0 0 0
1 1 800f0320 00000110 0b000001 0 0
1 1 800f0320 00000120 0b000002 0 0
1 1 800f0320 00000130 0b000003 0 0
1 1 800f0320 00000140 0b000004 0 0
1 1 800f0320 00000150 0b000005 0 0
1 1 800f0320 00000160 0b000006 0 0
1 1 800f0320 00000170 0b000007 0 0
1 1 800f0320 00000180 0b000008 0 0
1 1 800f0320 00000190 0b000009 0 0
4 1 1 0 0 0 0
3 10 0aa0000c 00000110 0 0 0
3 14 0aa00010 0b000001 0 0 0
3 10 0aa00014 00000120 0 0 0
3 14 0aa00018 0b000002 0 0 0
3 18 0aa0001c 00000006 0 0 0
4 0 1 0 0 0 0
2 00 00010000 0 0 0 0
1 1 30000000 0000abcd 0a000010 0 0
1 0 40000020 00000000 0a000011 2 40000020
3 0c 0aa00020 0000abcd 0 0 0
2 00 00000000 0 0 0 0
5 1 0 0 0 0 0
1 1 50000000 000000a1 0a000020 1 50000000
1 1 800e0010 000000a2 0a000021 3 800e0010
3 04 0aa00024 00001000 0 0 0
1 0 40000030 00000000 0a000022 2 40000030
1 1 800e0014 000000a3 0a000023 3 800e0014
3 08 0aa00028 00000a00 0 0 0
1 1 800e0018 000000a4 0a000024 3 800e0018
1 1 50000004 000000a5 0a000025 1 50000004
1 0 40000034 00000000 0a000026 2 40000034
5 0 0 0 0 0 0

// ==== bench/erx_core_tb.sv ====
`timescale 1ns/1ps

module erx_core_tb import erx_pkg::*; ();

   logic    clk;
   logic    rst_n;
   logic    rx_access;
   packet_t rx_packet;
   logic    rxwr_wait;
   logic    rxrd_wait;
   logic    rxrr_wait;
   logic    erx_cfg_access;
   packet_t erx_cfg_packet;
   logic    rx_rd_wait;
   logic    rx_wr_wait;
   logic    rxwr_access;
   logic    rxrd_access;
   logic    rxrr_access;
   packet_t rxwr_packet;
   packet_t rxrd_packet;
   packet_t rxrr_packet;
   logic    erx_cfg_wait;
   logic    mailbox_full;
   logic    mailbox_not_empty;

   packet_t     exp_wr[$];       // Expected per queue, in order
   packet_t     exp_rd[$];
   packet_t     exp_rr_link[$];
   packet_t     exp_rr_cfg[$];   // Config replies
   logic [31:0] fld [256][7];    // Parsed stimulus lines
   int          n_ops;
   logic        rand_en;
   integer      seed;
   logic [31:0] rnd;

   erx_core u_dut (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;  // 4 ns
   end

   task automatic report_failure();
      $display("Verification failed");
      $fatal(1, "run stopped");
   endtask

   task automatic check_packet(string name, packet_t got, packet_t exp);
      if (got !== exp) begin
         $display("Error %s got %h expected %h", name, got, exp);
         report_failure();
      end
   endtask

   task automatic check_word(string name, logic [31:0] got, logic [31:0] exp);
      if (got !== exp) begin
         $display("Error %s got %h expected %h", name, got, exp);
         report_failure();
      end
   endtask

   task automatic check_flag(string name, logic got, logic exp);
      if (got !== exp) begin
         $display("Error %s got %h expected %h", name, got, exp);
         report_failure();
      end
   endtask

   // Queue waits, random only in back-pressure sections
   initial begin
      seed      = 32'he01e6ba2;
      rxwr_wait = 1'b0;
      rxrd_wait = 1'b0;
      rxrr_wait = 1'b0;
      forever begin
         @(posedge clk);
         if (rand_en) begin
            rnd = $random(seed);
            rxwr_wait <= rnd[0];
            rxrd_wait <= rnd[1];
            rxrr_wait <= rnd[2];
         end else begin
            rxwr_wait <= 1'b0;
            rxrd_wait <= 1'b0;
            rxrr_wait <= 1'b0;
         end
      end
   end

   // Transfers counted mid-cycle where strobes and waits are settled
   initial begin
      forever begin
         @(negedge clk);
         if (rst_n) begin
            if (rxwr_access && !rxwr_wait) begin
               if (exp_wr.size() == 0) begin
                  $display("Unexpected packet on the write queue");
                  report_failure();
               end else begin
                  check_packet("rxwr_packet", rxwr_packet, exp_wr.pop_front());
               end
            end
            if (rxrd_access && !rxrd_wait) begin
               if (exp_rd.size() == 0) begin
                  $display("Unexpected packet on the read queue");
                  report_failure();
               end else begin
                  check_packet("rxrd_packet", rxrd_packet, exp_rd.pop_front());
               end
            end
            if (rxrr_access && !rxrr_wait) begin
               if (rxrr_packet.dstaddr[31:20] == core_id) begin  // Link read response
                  if (exp_rr_link.size() == 0) begin
                     $display("Unexpected read response on the read-response queue");
                     report_failure();
                  end else begin
                     check_packet("rxrr_packet", rxrr_packet, exp_rr_link.pop_front());
                  end
               end else if (exp_rr_cfg.size() == 0) begin
                  $display("Unexpected config reply on the read-response queue");
                  report_failure();
               end else begin
                  check_word("rxrr_packet.data", rxrr_packet.data, exp_rr_cfg[0].data);
                  check_packet("rxrr_packet", rxrr_packet, exp_rr_cfg.pop_front());
               end
            end
         end
      end
   end

   // Pipeline drained, then two register stages plus flag update
   task automatic settle();
      while (exp_wr.size() + exp_rd.size() + exp_rr_link.size() + exp_rr_cfg.size() != 0) begin
         @(posedge clk);
      end
      repeat (3) @(posedge clk);
   endtask

   task automatic send_link(packet_t p);
      logic taken;
      taken = 1'b0;
      @(posedge clk);
      rx_access <= 1'b1;
      rx_packet <= p;
      while (!taken) begin
         @(negedge clk);
         taken = !rx_wr_wait;  // Held by the link while stalled
         @(posedge clk);
      end
      rx_access <= 1'b0;
   endtask

   task automatic send_cfg(packet_t p);
      logic taken;
      taken = 1'b0;
      @(posedge clk);
      erx_cfg_access <= 1'b1;
      erx_cfg_packet <= p;
      while (!taken) begin
         @(negedge clk);
         taken = !erx_cfg_wait;
         @(posedge clk);
      end
      erx_cfg_access <= 1'b0;
   endtask

   task automatic load_stimulus();
      int          fd;
      int          cnt;
      string       line;
      logic [31:0] f [7];
      fd = $fopen("bench/erx_stimulus.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the stimulus file");
         report_failure();
      end else begin
         while (!$feof(fd)) begin
            line = "";
            cnt = $fgets(line, fd);
            if (line.len() > 1 && line.getc(0) != "#") begin
               cnt = $sscanf(line, "%h %h %h %h %h %h %h",
                             f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
               if (cnt == 7) begin
                  for (int i = 0; i < 7; i++) begin
                     fld[n_ops][i] = f[i];
                  end
                  n_ops++;
               end
            end
         end
         $fclose(fd);
         if (n_ops == 0) begin
            $display("The stimulus file holds no operations");
            report_failure();
         end
      end
   endtask

   initial begin
      wait (n_ops > 0);
      repeat (n_ops * 50) @(posedge clk);
      $display("Timeout: the DUT stopped moving packets before the stimulus ended");
      report_failure();
   end

   initial begin
      packet_t p;
      packet_t e;
      rst_n          = 1'b0;
      rx_access      = 1'b0;
      rx_packet      = '0;
      erx_cfg_access = 1'b0;
      erx_cfg_packet = '0;
      rand_en        = 1'b0;
      n_ops          = 0;
      load_stimulus();
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      for (int i = 0; i < n_ops; i++) begin
         p = '0;
         case (fld[i][0])
            1: begin  // Link packet
               p.write = fld[i][1][0];
               p.datamode = 2'd2;
               p.dstaddr = fld[i][2];
               p.data = fld[i][3];
               p.srcaddr = fld[i][4];
               e = p;
               e.dstaddr = fld[i][6];
               case (fld[i][5])
                  1: exp_wr.push_back(e);
                  2: exp_rd.push_back(e);
                  3: exp_rr_link.push_back(e);
                  default: ;  // Consumed inside the core
               endcase
               send_link(p);
            end
            2: begin
               settle();
               p.write = 1'b1;
               p.dstaddr = {24'h0, fld[i][1][7:0]};
               p.data = fld[i][2];
               send_cfg(p);
            end
            3: begin
               if (!rand_en) settle();
               p.dstaddr = {24'h0, fld[i][1][7:0]};
               p.srcaddr = fld[i][2];
               e = '0;
               e.write = 1'b1;  // Reply swaps the addresses
               e.dstaddr = p.srcaddr;
               e.srcaddr = p.dstaddr;
               e.data = fld[i][3];
               exp_rr_cfg.push_back(e);
               send_cfg(p);
            end
            4: begin
               settle();
               @(negedge clk);
               check_flag("mailbox_full", mailbox_full, fld[i][1][0]);
               check_flag("mailbox_not_empty", mailbox_not_empty, fld[i][2][0]);
            end
            5: begin
               settle();
               rand_en <= fld[i][1][0];
            end
            default: begin
               $display("Unknown operation in the stimulus file");
               report_failure();
            end
         endcase
      end
      settle();
      $display("Verification passed");
      $finish;
   end

endmodule

// ==== bench/erx_core_sva.sv ====
`timescale 1ns/1ps

module erx_core_sva import erx_pkg::*; (
   input logic    clk,
   input logic    rst_n,
   input logic    stall,
   input logic    rx_rd_wait,
   input logic    rx_wr_wait,
   input logic    rxwr_wait,
   input logic    rxrd_wait,
   input logic    rxrr_wait,
   input logic    rxwr_access,
   input packet_t rxwr_packet,
   input logic    rxrd_access,
   input packet_t rxrd_packet,
   input logic    rxrr_access,
   input packet_t rxrr_packet,
   input logic    erx_cfg_wait
);

   logic link_busy;   // Write or read queue refuses its packet
   logic any_strobe;  // Some queue strobe up

   assign link_busy  = (rxwr_access & rxwr_wait) | (rxrd_access & rxrd_wait);
   assign any_strobe = rxwr_access | rxrd_access | rxrr_access;

   // No queue strobe while reset is applied
   assert property (@(posedge clk) !rst_n |-> !any_strobe)
      else $error("queue strobe high during reset");

   // Only one queue served per cycle
   assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0({rxwr_access, rxrd_access, rxrr_access}))
      else $error("more than one queue strobe high");

   // Strobes and packets frozen while the pipe is stalled
   assert property (@(posedge clk) disable iff (!rst_n)
      stall |=> ($stable({rxwr_access, rxrd_access, rxrr_access})
                 && $stable(rxwr_packet) && $stable(rxrd_packet)
                 && (!rxrr_access || $stable(rxrr_packet))))
      else $error("queue output changed under stall");

   // Both link waits follow back-pressure from the queues
   assert property (@(posedge clk) disable iff (!rst_n)
      (rx_wr_wait == rx_rd_wait)
      && (!link_busy || rx_wr_wait)
      && (!rx_wr_wait || link_busy || (rxrr_access && rxrr_wait)))
      else $error("link wait does not follow queue back-pressure");

   // Config port held only while a queue strobe is up
   assert property (@(posedge clk) disable iff (!rst_n)
      erx_cfg_wait |-> any_strobe)
      else $error("config wait high with all queues idle");

endmodule

bind erx_core erx_core_sva u_sva (.*);

// ==== logic/erx_core.sv ====
`timescale 1ns/1ps

module erx_core import erx_pkg::*, erx_cfg_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,
   input  logic    rx_access,
   input  packet_t rx_packet,
   input  logic    rxwr_wait,
   input  logic    rxrd_wait,
   input  logic    rxrr_wait,
   input  logic    erx_cfg_access,
   input  packet_t erx_cfg_packet,
   output logic    rx_rd_wait,
   output logic    rx_wr_wait,
   output logic    rxwr_access,
   output packet_t rxwr_packet,
   output logic    rxrd_access,
   output packet_t rxrd_packet,
   output logic    rxrr_access,
   output packet_t rxrr_packet,
   output logic    erx_cfg_wait,
   output logic    mailbox_full,
   output logic    mailbox_not_empty
);

   logic        stall;          // Global pipeline hold
   logic        test_mode;
   logic        test_access;    // Test write from the link
   logic [31:0] test_data;
   logic        prot_access;    // Protocol stage out
   pkt_class_t  prot_class;
   packet_t     prot_packet;
   remap_cfg_t  remap;
   logic        rmp_access;     // Remap stage out
   pkt_class_t  rmp_class;
   packet_t     rmp_packet;
   logic [63:0] mbox_entry;
   logic [3:0]  mbox_count;
   logic        mbox_pop;
   logic        reply_access;   // Config reply slot
   packet_t     reply_packet;
   logic        reply_taken;

   erx_protocol u_protocol (
      .clk         (clk),
      .rst_n       (rst_n),
      .rx_access   (rx_access),
      .rx_packet   (rx_packet),
      .stall       (stall),
      .test_mode   (test_mode),
      .out_access  (prot_access),
      .out_class   (prot_class),
      .out_packet  (prot_packet),
      .test_access (test_access),
      .test_data   (test_data)
   );

   erx_remap u_remap (
      .clk        (clk),
      .rst_n      (rst_n),
      .stall      (stall),
      .in_access  (prot_access),
      .in_class   (prot_class),
      .in_packet  (prot_packet),
      .remap      (remap),
      .out_access (rmp_access),
      .out_class  (rmp_class),
      .out_packet (rmp_packet)
   );

   erx_cfg u_cfg (
      .clk          (clk),
      .rst_n        (rst_n),
      .cfg_access   (erx_cfg_access),
      .cfg_packet   (erx_cfg_packet),
      .test_access  (test_access),
      .test_data    (test_data),
      .mbox_entry   (mbox_entry),
      .mbox_count   (mbox_count),
      .reply_taken  (reply_taken),
      .cfg_wait     (erx_cfg_wait),
      .remap        (remap),
      .test_mode    (test_mode),
      .mbox_pop     (mbox_pop),
      .reply_access (reply_access),
      .reply_packet (reply_packet)
   );

   erx_mailbox u_mailbox (
      .clk               (clk),
      .rst_n             (rst_n),
      .snoop_access      (rmp_access),  // Taps the remapped stream
      .snoop_class       (rmp_class),
      .snoop_packet      (rmp_packet),
      .pop               (mbox_pop),
      .entry             (mbox_entry),
      .count             (mbox_count),
      .mailbox_full      (mailbox_full),
      .mailbox_not_empty (mailbox_not_empty)
   );

   erx_distributor u_distributor (
      .in_access   (rmp_access),
      .in_class    (rmp_class),
      .in_packet   (rmp_packet),
      .rr_access   (reply_access),
      .rr_packet   (reply_packet),
      .rxwr_wait   (rxwr_wait),
      .rxrd_wait   (rxrd_wait),
      .rxrr_wait   (rxrr_wait),
      .rxwr_access (rxwr_access),
      .rxwr_packet (rxwr_packet),
      .rxrd_access (rxrd_access),
      .rxrd_packet (rxrd_packet),
      .rxrr_access (rxrr_access),
      .rxrr_packet (rxrr_packet),
      .reply_taken (reply_taken),
      .stall       (stall)
   );

   // Both link waits are the one stall level
   assign rx_rd_wait = stall;
   assign rx_wr_wait = stall;

endmodule

// ==== logic/erx_distributor.sv ====
`timescale 1ns/1ps

module erx_distributor import erx_pkg::*; (
   input  logic       in_access,
   input  pkt_class_t in_class,
   input  packet_t    in_packet,
   input  logic       rr_access,
   input  packet_t    rr_packet,
   input  logic       rxwr_wait,
   input  logic       rxrd_wait,
   input  logic       rxrr_wait,
   output logic       rxwr_access,
   output packet_t    rxwr_packet,
   output logic       rxrd_access,
   output packet_t    rxrd_packet,
   output logic       rxrr_access,
   output packet_t    rxrr_packet,
   output logic       reply_taken,
   output logic       stall
);

   logic mbox_hit;   // Consumed by the mailbox
   logic fwd;        // Link packet leaves on a queue
   logic link_rr;    // Link read response on rxrr
   logic cfg_slot;   // Config reply may use rxrr

   assign mbox_hit = (in_class == cls_write)
                     && (in_packet.dstaddr == {core_id, mailbox_addr});
   assign fwd      = in_access & ~mbox_hit;

   // Steering by class
   assign rxwr_access = fwd & (in_class == cls_write);
   assign rxrd_access = fwd & (in_class == cls_read);
   assign link_rr     = fwd & (in_class == cls_rresp);

   // Config reply only when no link packet is on any queue
   assign cfg_slot    = rr_access & ~fwd;
   assign rxrr_access = link_rr | cfg_slot;
   assign rxrr_packet = link_rr ? in_packet : rr_packet;
   assign reply_taken = cfg_slot & ~rxrr_wait;

   assign rxwr_packet = in_packet;
   assign rxrd_packet = in_packet;

   // Hold the pipe while the target queue pushes back
   assign stall = (rxwr_access & rxwr_wait)
                  | (rxrd_access & rxrd_wait)
                  | (link_rr & rxrr_wait);

endmodule

// ==== logic/erx_mailbox.sv ====
`timescale 1ns/1ps

module erx_mailbox import erx_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        snoop_access,
   input  pkt_class_t  snoop_class,
   input  packet_t     snoop_packet,
   input  logic        pop,
   output logic [63:0] entry,
   output logic [3:0]  count,
   output logic        mailbox_full,
   output logic        mailbox_not_empty
);

   logic [63:0] mem [mailbox_depth];             // {srcaddr, data} pairs
   logic [$clog2(mailbox_depth)-1:0] wr_ptr;     // Wraps at depth
   logic [$clog2(mailbox_depth)-1:0] rd_ptr;
   logic        hit;                             // Write aimed at the mailbox
   logic        push;
   logic        pop_ok;

   assign hit = snoop_access && (snoop_class == cls_write)
                && (snoop_packet.dstaddr == {core_id, mailbox_addr});
   assign push   = hit & ~mailbox_full;          // Overflow is dropped
   assign pop_ok = pop & mailbox_not_empty;      // Pop of empty ignored

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= {snoop_packet.srcaddr, snoop_packet.data};
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop_ok) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop_ok})
            2'b10:   count <= count + 4'd1;
            2'b01:   count <= count - 4'd1;
            default: count <= count;  // Both or neither
         endcase
      end
   end

   // Flags follow the count register
   assign entry             = mem[rd_ptr];
   assign mailbox_full      = (count == 4'(mailbox_depth));
   assign mailbox_not_empty = (count != 4'd0);

endmodule

// ==== logic/erx_cfg.sv ====
`timescale 1ns/1ps

module erx_cfg import erx_pkg::*, erx_cfg_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        cfg_access,
   input  packet_t     cfg_packet,
   input  logic        test_access,
   input  logic [31:0] test_data,
   input  logic [63:0] mbox_entry,
   input  logic [3:0]  mbox_count,
   input  logic        reply_taken,
   output logic        cfg_wait,
   output remap_cfg_t  remap,
   output logic        test_mode,
   output logic        mbox_pop,
   output logic        reply_access,
   output packet_t     reply_packet
);

   cfg_req_t    req;         // Decoded request
   logic        accept;      // Request taken this cycle
   logic        wr_en;
   logic        rd_en;
   logic [31:0] rdata;       // Register read mux
   remap_cfg_t  remap_q;
   logic        test_mode_q;
   logic [31:0] testdata_q;

   always_comb begin
      req.we    = cfg_packet.write;
      req.addr  = cfg_packet.dstaddr[7:0];
      req.wdata = cfg_packet.data;
   end

   // Port held only while an untaken reply sits in the slot
   assign cfg_wait = reply_access & ~reply_taken;
   assign accept   = cfg_access & ~cfg_wait;
   assign wr_en    = accept & req.we;
   assign rd_en    = accept & ~req.we;
   assign mbox_pop = rd_en & (req.addr == reg_mbox_hi); // Hi word read retires entry

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         remap_q     <= '0;  // Mode none
         test_mode_q <= 1'b0;
         testdata_q  <= '0;
      end else begin
         if (wr_en) begin
            case (req.addr)
               reg_config: begin
                  remap_q.mode <= remap_mode_t'(req.wdata[cfg_mode_lsb +: 2]);
                  remap_q.sel  <= req.wdata[cfg_sel_lsb +: 12];
                  test_mode_q  <= req.wdata[cfg_test_bit];
               end
               reg_remap_base:    remap_q.base    <= req.wdata;
               reg_remap_pattern: remap_q.pattern <= req.wdata[11:0];
               reg_testdata:      testdata_q      <= req.wdata;
               default:           ;  // Read-only or unmapped
            endcase
         end
         if (test_access) begin
            testdata_q <= test_data;  // Link test data wins
         end
      end
   end

   always_comb begin
      rdata = '0;
      case (req.addr)
         reg_config: begin
            rdata[cfg_mode_lsb +: 2]  = remap_q.mode;
            rdata[cfg_sel_lsb +: 12]  = remap_q.sel;
            rdata[cfg_test_bit]       = test_mode_q;
         end
         reg_remap_base:    rdata        = remap_q.base;
         reg_remap_pattern: rdata[11:0]  = remap_q.pattern;
         reg_testdata:      rdata        = testdata_q;
         reg_mbox_lo:       rdata        = mbox_entry[31:0];   // Data word
         reg_mbox_hi:       rdata        = mbox_entry[63:32];  // Sender address
         reg_mbox_status:   rdata[3:0]   = mbox_count;
         default:           rdata        = '0;
      endcase
   end

   // Reply slot
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         reply_access <= 1'b0;
      end else if (rd_en) begin
         reply_access <= 1'b1;
      end else if (reply_taken) begin
         reply_access <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en) begin
         reply_packet.write    <= 1'b1;                // Replies travel as writes
         reply_packet.datamode <= cfg_packet.datamode;
         reply_packet.ctrlmode <= cfg_packet.ctrlmode;
         reply_packet.dstaddr  <= cfg_packet.srcaddr;  // Back to the requester
         reply_packet.srcaddr  <= cfg_packet.dstaddr;
         reply_packet.data     <= rdata;
      end
   end

   assign remap     = remap_q;
   assign test_mode = test_mode_q;

endmodule

// ==== logic/erx_remap.sv ====
`timescale 1ns/1ps

module erx_remap import erx_pkg::*, erx_cfg_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       stall,
   input  logic       in_access,
   input  pkt_class_t in_class,
   input  packet_t    in_packet,
   input  remap_cfg_t remap,
   output logic       out_access,
   output pkt_class_t out_class,
   output packet_t    out_packet
);

   packet_t     remapped;   // Next value of the packet register
   logic [11:0] static_hi;  // Rewritten dstaddr[31:20]

   assign static_hi = (in_packet.dstaddr[31:20] & ~remap.sel) | (remap.pattern & remap.sel);

   always_comb begin
      remapped = in_packet;
      if (in_class != cls_rresp) begin  // Responses keep their address
         case (remap.mode)
            remap_static:  remapped.dstaddr[31:20] = static_hi;
            remap_dynamic: remapped.dstaddr = in_packet.dstaddr + remap.base;
            default:       remapped = in_packet;  // No remap
         endcase
      end
   end

   // Second pipeline register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         out_access <= 1'b0;
         out_class  <= cls_write;
      end else if (!stall) begin
         out_access <= in_access;
         if (in_access) begin
            out_class <= in_class;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!stall && in_access) begin
         out_packet <= remapped;
      end
   end

endmodule

// ==== logic/erx_protocol.sv ====
`timescale 1ns/1ps

module erx_protocol import erx_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        rx_access,
   input  packet_t     rx_packet,
   input  logic        stall,
   input  logic        test_mode,
   output logic        out_access,
   output pkt_class_t  out_class,
   output packet_t     out_packet,
   output logic        test_access,
   output logic [31:0] test_data
);

   logic          acc_q;    // Link strobe, registered
   logic [pw-1:0] raw_q;    // Raw link bits, registered
   packet_t       pkt;      // Same bits as a struct
   logic          to_core;  // Targets our ID space
   logic          is_rresp;

   // Input register, frozen while downstream stalls
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         acc_q <= 1'b0;
      end else if (!stall) begin
         acc_q <= rx_access;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall && rx_access) begin
         raw_q <= rx_packet;  // Payload only moves with a strobe
      end
   end

   assign pkt = packet_t'(raw_q);

   // Read responses are writes into our rr region
   assign to_core  = (pkt.dstaddr[31:20] == core_id);
   assign is_rresp = pkt.write && to_core && (pkt.dstaddr[19:16] == rr_region);

   always_comb begin
      if (!pkt.write) begin
         out_class = cls_read;
      end else if (is_rresp) begin
         out_class = cls_rresp;
      end else begin
         out_class = cls_write;
      end
   end

   // Test mode swallows all writes
   assign out_access  = acc_q & ~(test_mode & pkt.write);
   assign out_packet  = pkt;
   assign test_access = acc_q & test_mode & pkt.write & ~stall; // Once per held packet
   assign test_data   = pkt.data;

endmodule

// ==== logic/erx_cfg_pkg.sv ====
package erx_cfg_pkg;

   // Register map, offsets in dstaddr[7:0] of a config packet
   localparam logic [7:0] reg_config        = 8'h00; // Remap mode, sel, test mode
   localparam logic [7:0] reg_remap_base    = 8'h04; // Dynamic remap offset
   localparam logic [7:0] reg_remap_pattern = 8'h08; // Static remap pattern
   localparam logic [7:0] reg_testdata      = 8'h0c; // Last test-mode data
   localparam logic [7:0] reg_mbox_lo       = 8'h10; // Mailbox head data
   localparam logic [7:0] reg_mbox_hi       = 8'h14; // Mailbox head srcaddr, pops
   localparam logic [7:0] reg_mbox_status   = 8'h18; // Mailbox fill count

   // Field layout of reg_config
   localparam int cfg_mode_lsb = 0;   // Remap mode, 2 bits
   localparam int cfg_sel_lsb  = 2;   // Static select mask, 12 bits
   localparam int cfg_test_bit = 16;  // Test mode enable

   typedef enum logic [1:0] {
      remap_none    = 2'd0,
      remap_static  = 2'd1,
      remap_dynamic = 2'd2
   } remap_mode_t;

   // Decoded config access
   typedef struct packed {
      logic        we;
      logic [7:0]  addr;
      logic [31:0] wdata;
   } cfg_req_t;

   // Settings driven into the remap stage
   typedef struct packed {
      remap_mode_t mode;
      logic [11:0] sel;      // Which of dstaddr[31:20] get replaced
      logic [11:0] pattern;  // Replacement bits
      logic [31:0] base;     // Added in dynamic mode
   } remap_cfg_t;

endpackage

// ==== logic/erx_pkg.sv ====
package erx_pkg;

   // Link-level constants
   localparam int pw = 104;                          // Packet width on every path
   localparam logic [11:0] core_id = 12'h800;        // Endpoint ID in dstaddr[31:20]
   localparam logic [19:0] mailbox_addr = 20'hf0320; // Mailbox offset inside ID space
   localparam logic [3:0] rr_region = 4'he;          // dstaddr[19:16] of read responses
   localparam int mailbox_depth = 8;                 // Mailbox FIFO entries

   // Mesh packet as it travels on the link
   typedef struct packed {
      logic        write;      // Write or read response
      logic [1:0]  datamode;   // Transfer size
      logic [4:0]  ctrlmode;   // Control bits
      logic [31:0] dstaddr;    // Target address
      logic [31:0] data;       // Payload
      logic [31:0] srcaddr;    // Return address for reads
   } packet_t;

   // Traffic class picked by the protocol stage
   typedef enum logic [1:0] {
      cls_write = 2'd0,        // Plain write
      cls_read  = 2'd1,        // Read request
      cls_rresp = 2'd2         // Read response into the rr region
   } pkt_class_t;

endpackage
